//--- logic/fetch_pkg.sv
// ********************
// Fetch front end shared definitions
// Address and line widths, fetch request and response, FSM states
// ********************
package fetch_pkg;

    // Byte address width of the fetch path
    localparam int ADDR_SIZE = 40;

    // Byte offset bits inside one 16-byte line
    localparam int LINE_OFFSET_BITS = 4;

    // One line carries four instructions
    localparam int LINE_BITS = 128;
    localparam int INSTR_BITS = 32;

    // Byte address of a fetch or a line
    typedef logic [ADDR_SIZE-1:0] addr_t;

    // Full cache line, instruction 0 in the low bits
    typedef logic [LINE_BITS-1:0] icache_line_t;

    // Single instruction word
    typedef logic [INSTR_BITS-1:0] instr_t;

    // Request from the PC generator to the icache interface
    typedef struct packed {
        // Fetch address is meaningful
        logic  valid;
        // Byte address of the instruction
        addr_t vaddr;
        // Drop the line held in the buffer
        logic  invalidate_buffer;
        // Clear every line of the cache
        logic  invalidate_icache;
        // Abandon the outstanding request after a redirect
        logic  inval_fetch;
    } req_cpu_icache_t;

    // Response from the icache interface to fetch
    typedef struct packed {
        // Instruction below is usable this cycle
        logic   valid;
        // Address it was fetched from
        addr_t  pc;
        // Selected instruction word
        instr_t data;
    } resp_icache_cpu_t;

    // Request FSM of the icache interface
    typedef enum logic {
        NoReq,
        ReqValid
    } icache_state_t;

endpackage

//--- logic/fetch_pc_gen.sv
// ********************
// Program counter generator
// Advances, holds or redirects the PC and forms the fetch request
// ********************
`timescale 1ns/100ps

module fetch_pc_gen #(
    parameter fetch_pkg::addr_t BOOT_ADDR = '0
) (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        redirect_valid_i,
    input  fetch_pkg::addr_t            redirect_addr_i,
    input  logic                        invalidate_i,
    input  logic                        fetch_ready_i,
    input  fetch_pkg::resp_icache_cpu_t resp_i,
    output fetch_pkg::req_cpu_icache_t  req_o
);

    fetch_pkg::addr_t pc_q;
    fetch_pkg::addr_t pc_d;
    // Request valid once out of reset
    logic             valid_q;
    // One-cycle flags toward the icache interface
    logic             inval_fetch_q;
    logic             inval_icache_q;
    // Current instruction consumed by decode
    logic             take_resp;

    assign take_resp = resp_i.valid & fetch_ready_i;

    // Redirect wins over sequential advance
    always_comb begin
        if (redirect_valid_i) begin
            pc_d = redirect_addr_i;
        end else if (take_resp) begin
            pc_d = pc_q + fetch_pkg::ADDR_SIZE'(4);
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q           <= BOOT_ADDR;
            valid_q        <= 1'b0;
            inval_fetch_q  <= 1'b0;
            inval_icache_q <= 1'b0;
        end else begin
            pc_q           <= pc_d;
            valid_q        <= 1'b1;
            // Kill the old request together with the new PC
            inval_fetch_q  <= redirect_valid_i;
            inval_icache_q <= invalidate_i;
        end
    end

    // Cache invalidate also flushes the line buffer
    always_comb begin
        req_o.valid             = valid_q;
        req_o.vaddr             = pc_q;
        req_o.invalidate_buffer = inval_icache_q;
        req_o.invalidate_icache = inval_icache_q;
        req_o.inval_fetch       = inval_fetch_q;
    end

endmodule

//--- logic/icache_interface.sv
// ********************
// Icache interface
// Line buffer and request FSM between fetch and the instruction cache
// ********************
`timescale 1ns/100ps

module icache_interface (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    // Fetch request
    input  fetch_pkg::req_cpu_icache_t  req_fetch_icache_i,
    // Cache response
    input  fetch_pkg::icache_line_t     icache_resp_datablock_i,
    input  fetch_pkg::addr_t            icache_resp_vaddr_i,
    input  logic                        icache_resp_valid_i,
    input  logic                        icache_req_ready_i,
    // Cache request
    output logic                        icache_invalidate_o,
    output fetch_pkg::addr_t            icache_req_addr_o,
    output logic                        icache_req_kill_o,
    output logic                        icache_req_valid_o,
    // Response to fetch
    output fetch_pkg::resp_icache_cpu_t resp_icache_fetch_o,
    // Performance event
    output logic                        buffer_miss_o
);

    localparam int TOP = fetch_pkg::ADDR_SIZE - 1;
    localparam int OFS = fetch_pkg::LINE_OFFSET_BITS;

    fetch_pkg::icache_state_t state_q;
    fetch_pkg::icache_state_t state_d;

    // Buffered line, its address and valid flag
    fetch_pkg::icache_line_t  line_q;
    fetch_pkg::addr_t         pc_buffer_q;
    logic                     valid_buffer_q;
    // Address of the request sent to the cache
    fetch_pkg::addr_t         old_pc_req_q;

    // Line used for word select, forwarded or buffered
    fetch_pkg::icache_line_t  line_int;
    logic                     buffer_miss_int;
    logic                     access_needed;
    logic                     do_request;
    logic                     new_addr_req;
    logic                     is_same_line;
    logic                     a_valid_resp;
    logic                     to_no_req;
    logic                     kill;

    // Miss when buffer empty or holding another line
    assign buffer_miss_int = ~valid_buffer_q |
                             (pc_buffer_q[TOP:OFS] != req_fetch_icache_i.vaddr[TOP:OFS]);

    assign access_needed = req_fetch_icache_i.valid & buffer_miss_int;

    // No new request while the buffer is being flushed
    assign do_request = access_needed &
                        ~req_fetch_icache_i.invalidate_buffer &
                        icache_req_ready_i;

    // Fetch moved to another line since the request
    assign new_addr_req = old_pc_req_q[TOP:OFS] != req_fetch_icache_i.vaddr[TOP:OFS];

    assign is_same_line = icache_resp_vaddr_i[TOP:OFS] == req_fetch_icache_i.vaddr[TOP:OFS];
    assign a_valid_resp = icache_resp_valid_i & is_same_line;

    assign to_no_req = new_addr_req |
                       a_valid_resp |
                       req_fetch_icache_i.inval_fetch |
                       req_fetch_icache_i.invalidate_icache;

    // Hold the issued address while waiting
    assign icache_req_addr_o = do_request ? req_fetch_icache_i.vaddr : old_pc_req_q;

    assign icache_req_kill_o   = req_fetch_icache_i.inval_fetch | kill;
    assign icache_invalidate_o = req_fetch_icache_i.invalidate_icache;

    // Request FSM
    always_comb begin
        case (state_q)
            fetch_pkg::NoReq: begin
                state_d                   = do_request ? fetch_pkg::ReqValid :
                                                         fetch_pkg::NoReq;
                icache_req_valid_o        = do_request;
                resp_icache_fetch_o.valid = ~buffer_miss_int;
                kill                      = 1'b0;
            end
            fetch_pkg::ReqValid: begin
                state_d                   = to_no_req ? fetch_pkg::NoReq :
                                                        fetch_pkg::ReqValid;
                icache_req_valid_o        = 1'b0;
                // Matching line is forwarded in the same cycle
                resp_icache_fetch_o.valid = ~buffer_miss_int | a_valid_resp;
                kill                      = new_addr_req;
            end
            default: begin
                state_d                   = fetch_pkg::NoReq;
                icache_req_valid_o        = 1'b0;
                resp_icache_fetch_o.valid = 1'b0;
                kill                      = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q        <= fetch_pkg::NoReq;
            valid_buffer_q <= 1'b0;
            pc_buffer_q    <= '0;
            old_pc_req_q   <= '0;
        end else begin
            state_q        <= state_d;
            valid_buffer_q <= (valid_buffer_q | a_valid_resp) &
                              ~req_fetch_icache_i.invalidate_buffer;
            // Tag follows the line loaded into the buffer
            if (a_valid_resp) begin
                pc_buffer_q <= req_fetch_icache_i.vaddr;
            end
            if (do_request && state_q == fetch_pkg::NoReq) begin
                old_pc_req_q <= req_fetch_icache_i.vaddr;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_valid_resp) begin
            line_q <= icache_resp_datablock_i;
        end
    end

    // Bypass a matching response, else read the buffer
    assign line_int = a_valid_resp ? icache_resp_datablock_i : line_q;

    // Word select on address bits 3 to 2
    always_comb begin
        resp_icache_fetch_o.pc = req_fetch_icache_i.vaddr;
        case (req_fetch_icache_i.vaddr[3:2])
            2'b00:   resp_icache_fetch_o.data = line_int[31:0];
            2'b01:   resp_icache_fetch_o.data = line_int[63:32];
            2'b10:   resp_icache_fetch_o.data = line_int[95:64];
            default: resp_icache_fetch_o.data = line_int[127:96];
        endcase
    end

    // Counts every cycle that needs the cache
    assign buffer_miss_o = access_needed;

endmodule

//--- logic/icache_array.sv
// ********************
// Direct-mapped instruction cache
// Tag and data store, hit path and line refill from memory
// ********************
`timescale 1ns/100ps

module icache_array #(
    parameter int unsigned ICACHE_SETS = 16
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    // Request from the icache interface
    input  logic                    req_valid_i,
    input  fetch_pkg::addr_t        req_addr_i,
    input  logic                    req_kill_i,
    input  logic                    invalidate_i,
    // Response to the icache interface
    output logic                    req_ready_o,
    output logic                    resp_valid_o,
    output fetch_pkg::addr_t        resp_vaddr_o,
    output fetch_pkg::icache_line_t resp_datablock_o,
    // Memory port
    output logic                    mem_req_valid_o,
    output fetch_pkg::addr_t        mem_req_addr_o,
    input  logic                    mem_req_ready_i,
    input  logic                    mem_resp_valid_i,
    input  fetch_pkg::icache_line_t mem_resp_data_i
);

    localparam int OFS      = fetch_pkg::LINE_OFFSET_BITS;
    localparam int IDX_BITS = $clog2(ICACHE_SETS);
    localparam int TAG_LSB  = OFS + IDX_BITS;
    localparam int TAG_BITS = fetch_pkg::ADDR_SIZE - TAG_LSB;

    typedef logic [IDX_BITS-1:0] idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    // Lookup, memory request, refill wait and fill
    typedef enum logic [2:0] {
        Idle,
        HitResp,
        MemReq,
        WaitRefill,
        Fill
    } array_state_t;

    array_state_t            state_q;
    array_state_t            state_d;

    // Storage, valid bits cleared by invalidate
    logic [ICACHE_SETS-1:0]  valid_q;
    tag_t                    tag_q  [ICACHE_SETS];
    fetch_pkg::icache_line_t data_q [ICACHE_SETS];

    // Accepted request and line to return
    fetch_pkg::addr_t        req_addr_q;
    fetch_pkg::icache_line_t line_q;
    // Response of the current request is dropped
    logic                    killed_q;

    idx_t                    req_idx;
    tag_t                    req_tag;
    idx_t                    fill_idx;
    tag_t                    fill_tag;
    logic                    lookup_hit;
    logic                    accept;
    logic                    fill_en;

    assign req_idx  = req_addr_i[OFS +: IDX_BITS];
    assign req_tag  = req_addr_i[fetch_pkg::ADDR_SIZE-1:TAG_LSB];
    assign fill_idx = req_addr_q[OFS +: IDX_BITS];
    assign fill_tag = req_addr_q[fetch_pkg::ADDR_SIZE-1:TAG_LSB];

    // Tag compare on the incoming address
    assign lookup_hit = valid_q[req_idx] & (tag_q[req_idx] == req_tag);
    assign accept     = req_valid_i & (state_q == Idle);
    assign fill_en    = (state_q == WaitRefill) & mem_resp_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            Idle: begin
                if (accept) begin
                    state_d = lookup_hit ? HitResp : MemReq;
                end
            end
            HitResp: state_d = Idle;
            MemReq: begin
                // Hold the memory request until taken
                if (mem_req_ready_i) begin
                    state_d = WaitRefill;
                end
            end
            WaitRefill: begin
                if (mem_resp_valid_i) begin
                    state_d = Fill;
                end
            end
            Fill:    state_d = Idle;
            default: state_d = Idle;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q  <= Idle;
            killed_q <= 1'b0;
            valid_q  <= '0;
        end else begin
            state_q <= state_d;
            // Kill only applies to an accepted request
            if (state_q == Idle) begin
                killed_q <= 1'b0;
            end else if (req_kill_i) begin
                killed_q <= 1'b1;
            end
            if (invalidate_i) begin
                valid_q <= '0;
            end
            // Refill lands even after a kill
            if (fill_en) begin
                valid_q[fill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_addr_q <= req_addr_i;
            line_q     <= data_q[req_idx];
        end
        if (fill_en) begin
            tag_q[fill_idx]  <= fill_tag;
            data_q[fill_idx] <= mem_resp_data_i;
            line_q           <= mem_resp_data_i;
        end
    end

    assign req_ready_o      = state_q == Idle;
    // One-cycle pulse, after a hit or with the fill
    assign resp_valid_o     = ((state_q == HitResp) | (state_q == Fill)) &
                              ~killed_q & ~req_kill_i;
    assign resp_vaddr_o     = {req_addr_q[fetch_pkg::ADDR_SIZE-1:OFS], {OFS{1'b0}}};
    assign resp_datablock_o = line_q;

    // Line-aligned memory request
    assign mem_req_valid_o = state_q == MemReq;
    assign mem_req_addr_o  = {req_addr_q[fetch_pkg::ADDR_SIZE-1:OFS], {OFS{1'b0}}};

endmodule

//--- logic/fetch_frontend.sv
// ********************
// Fetch front end top
// PC generator, icache interface and cache array
// ********************
`timescale 1ns/100ps

module fetch_frontend #(
    parameter fetch_pkg::addr_t BOOT_ADDR   = 40'h00_8000_0000,
    parameter int unsigned      ICACHE_SETS = 16
) (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    // Control from the core
    input  logic                        redirect_valid_i,
    input  fetch_pkg::addr_t            redirect_addr_i,
    input  logic                        invalidate_i,
    input  logic                        fetch_ready_i,
    // Instruction toward decode
    output fetch_pkg::resp_icache_cpu_t fetch_o,
    // Memory port
    output logic                        mem_req_valid_o,
    output fetch_pkg::addr_t            mem_req_addr_o,
    input  logic                        mem_req_ready_i,
    input  logic                        mem_resp_valid_i,
    input  fetch_pkg::icache_line_t     mem_resp_data_i,
    // Performance event
    output logic                        buffer_miss_o
);

    fetch_pkg::req_cpu_icache_t fetch_req;

    // Interface to array
    logic                       cache_req_valid;
    fetch_pkg::addr_t           cache_req_addr;
    logic                       cache_req_kill;
    logic                       cache_invalidate;
    // Array to interface
    logic                       cache_req_ready;
    logic                       cache_resp_valid;
    fetch_pkg::addr_t           cache_resp_vaddr;
    fetch_pkg::icache_line_t    cache_resp_line;

    // Response to decode also steps the PC
    fetch_pc_gen #(
        .BOOT_ADDR (BOOT_ADDR)
    ) i_pc_gen (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_addr_i  (redirect_addr_i),
        .invalidate_i     (invalidate_i),
        .fetch_ready_i    (fetch_ready_i),
        .resp_i           (fetch_o),
        .req_o            (fetch_req)
    );

    icache_interface i_icache_if (
        .clk_i                   (clk_i),
        .rstn_i                  (rstn_i),
        .req_fetch_icache_i      (fetch_req),
        .icache_resp_datablock_i (cache_resp_line),
        .icache_resp_vaddr_i     (cache_resp_vaddr),
        .icache_resp_valid_i     (cache_resp_valid),
        .icache_req_ready_i      (cache_req_ready),
        .icache_invalidate_o     (cache_invalidate),
        .icache_req_addr_o       (cache_req_addr),
        .icache_req_kill_o       (cache_req_kill),
        .icache_req_valid_o      (cache_req_valid),
        .resp_icache_fetch_o     (fetch_o),
        .buffer_miss_o           (buffer_miss_o)
    );

    icache_array #(
        .ICACHE_SETS (ICACHE_SETS)
    ) i_icache (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .req_valid_i      (cache_req_valid),
        .req_addr_i       (cache_req_addr),
        .req_kill_i       (cache_req_kill),
        .invalidate_i     (cache_invalidate),
        .req_ready_o      (cache_req_ready),
        .resp_valid_o     (cache_resp_valid),
        .resp_vaddr_o     (cache_resp_vaddr),
        .resp_datablock_o (cache_resp_line),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_data_i  (mem_resp_data_i)
    );

endmodule

//--- verification/tb_fetch_frontend.sv
// ********************
// Fetch front end testbench
// Memory model, file-driven redirects, data and timing checks
// ********************
`timescale 1ns/100ps

module tb_fetch_frontend;

    localparam int MAX_TESTS = 16;

    logic                        clk_i;
    logic                        rstn_i;
    logic                        redirect_valid_i;
    fetch_pkg::addr_t            redirect_addr_i;
    logic                        invalidate_i;
    logic                        fetch_ready_i;
    fetch_pkg::resp_icache_cpu_t fetch_o;
    logic                        mem_req_valid_o;
    fetch_pkg::addr_t            mem_req_addr_o;
    logic                        mem_req_ready_i;
    logic                        mem_resp_valid_i;
    fetch_pkg::icache_line_t     mem_resp_data_i;
    logic                        buffer_miss_o;

    // Test records from the data file
    reg [8*24-1:0]               rec_name [MAX_TESTS];
    fetch_pkg::addr_t            rec_target [MAX_TESTS];
    int                          rec_count [MAX_TESTS];
    int                          rec_lat [MAX_TESTS];
    int                          rec_inval [MAX_TESTS];
    int                          num_tests;
    reg [8*24-1:0]               cur_name;

    integer                      seed = 32'h12c3_4a26;
    int                          mem_latency;
    int                          mem_reqs;
    logic                        mem_busy;
    real                         limit_ns;

    // Expected cache contents, one line address per set
    logic [15:0]                 cached_vld;
    fetch_pkg::addr_t            cached_line [16];

    fetch_frontend #(
        .BOOT_ADDR   (40'h00_8000_0000),
        .ICACHE_SETS (16)
    ) i_dut (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_addr_i  (redirect_addr_i),
        .invalidate_i     (invalidate_i),
        .fetch_ready_i    (fetch_ready_i),
        .fetch_o          (fetch_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_data_i  (mem_resp_data_i),
        .buffer_miss_o    (buffer_miss_o)
    );

    always begin
        #10 clk_i = ~clk_i;
    end

    // Memory word at a byte address
    function automatic fetch_pkg::instr_t word_at(input fetch_pkg::addr_t a);
        logic [31:0] a32;
        a32 = {a[31:2], 2'b00};
        return a32 * 32'h9e37_79b1;
    endfunction

    function automatic fetch_pkg::icache_line_t line_data(input fetch_pkg::addr_t base);
        fetch_pkg::icache_line_t l;
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = word_at(base + 40'(4 * i));
        end
        return l;
    endfunction

    task automatic check_value(input reg [8*24-1:0] what, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERR %0s %0s expected %h actual %h", cur_name, what, exp_v, act_v);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Request ready drops at random
    always begin
        @(posedge clk_i);
        #2 mem_req_ready_i = ($unsigned($random(seed)) % 4) != 0;
    end

    // Line memory with per-test latency plus jitter
    initial begin : memory_model
        logic             waiting;
        fetch_pkg::addr_t held_addr;
        fetch_pkg::addr_t line;
        int               delay;
        waiting  = 1'b0;
        mem_busy = 1'b0;
        forever begin
            @(negedge clk_i);
            if (rstn_i && waiting) begin
                check_value("mem_req_valid_held", 1, mem_req_valid_o);
                check_value("mem_req_addr_held", held_addr, mem_req_addr_o);
            end
            if (rstn_i && mem_req_valid_o) begin
                if (mem_req_ready_i) begin
                    waiting = 1'b0;
                    line    = mem_req_addr_o;
                    // Lines fetched since the last invalidate must hit
                    check_value("refetch_of_cached_line", 0,
                                cached_vld[line[7:4]] && cached_line[line[7:4]] == line);
                    cached_vld[line[7:4]]  = 1'b1;
                    cached_line[line[7:4]] = line;
                    mem_reqs++;
                    mem_busy = 1'b1;
                    delay    = mem_latency + ($unsigned($random(seed)) % 4);
                    repeat (delay) @(posedge clk_i);
                    #2;
                    mem_resp_valid_i = 1'b1;
                    mem_resp_data_i  = line_data(line);
                    @(posedge clk_i);
                    #2;
                    mem_resp_valid_i = 1'b0;
                    mem_busy         = 1'b0;
                end else begin
                    waiting   = 1'b1;
                    held_addr = mem_req_addr_o;
                end
            end
        end
    end

    initial begin : watchdog
        wait (limit_ns > 0.0);
        #(limit_ns);
        $display("Timeout: the front end stopped delivering instructions");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic redirect_to(input fetch_pkg::addr_t target);
        @(posedge clk_i);
        #2;
        redirect_valid_i = 1'b1;
        redirect_addr_i  = target;
        @(posedge clk_i);
        #2;
        redirect_valid_i = 1'b0;
    endtask

    task automatic run_test(input int t);
        fetch_pkg::addr_t  expected_pc;
        fetch_pkg::addr_t  delivered;
        fetch_pkg::addr_t  held_pc;
        fetch_pkg::instr_t held_data;
        int                got;
        int                reqs_before;
        logic              stalled;
        logic              seen_line;
        logic              miss_seen;
        cur_name      = rec_name[t];
        mem_latency   = rec_lat[t];
        fetch_ready_i = 1'b1;
        if (rec_inval[t] != 0) begin
            while (mem_busy || mem_req_valid_o) begin
                @(posedge clk_i);
                #2;
            end
            invalidate_i = 1'b1;
            cached_vld   = '0;
            @(posedge clk_i);
            #2;
            invalidate_i = 1'b0;
        end
        // Decoy line so the real redirect tends to hit an open miss
        redirect_to(rec_target[t] + 40'h80);
        for (int w = 0; w < 6 && !mem_req_valid_o; w++) begin
            @(posedge clk_i);
            #2;
        end
        reqs_before = mem_reqs;
        redirect_to(rec_target[t]);
        expected_pc = rec_target[t];
        got         = 0;
        stalled     = 1'b0;
        seen_line   = 1'b0;
        miss_seen   = 1'b0;
        while (got < rec_count[t]) begin
            @(negedge clk_i);
            if (stalled) begin
                check_value("stall_valid", 1, fetch_o.valid);
                check_value("stall_pc", held_pc, fetch_o.pc);
                check_value("stall_data", held_data, fetch_o.data);
            end
            if (buffer_miss_o) begin
                miss_seen = 1'b1;
                if (seen_line && fetch_o.pc[39:4] == delivered[39:4]) begin
                    check_value("miss_in_buffered_line", 0, 1);
                end
            end
            if (fetch_o.valid && fetch_ready_i) begin
                check_value("pc", expected_pc, fetch_o.pc);
                check_value("data", word_at(expected_pc), fetch_o.data);
                // New line needs its own miss since the last accepted word
                if (seen_line && fetch_o.pc[39:4] != delivered[39:4]) begin
                    check_value("miss_for_new_line", 1, miss_seen);
                end
                miss_seen   = 1'b0;
                delivered   = fetch_o.pc;
                seen_line   = 1'b1;
                expected_pc = expected_pc + 40'd4;
                got++;
            end
            stalled   = fetch_o.valid && !fetch_ready_i;
            held_pc   = fetch_o.pc;
            held_data = fetch_o.data;
            @(posedge clk_i);
            #2 fetch_ready_i = ($unsigned($random(seed)) % 4) != 0;
        end
        if (rec_inval[t] != 0) begin
            check_value("refill_after_invalidate", 1, mem_reqs > reqs_before);
        end
    endtask

    initial begin : main
        int          fd;
        int          n;
        int          total;
        int          max_lat;
        reg [8*96-1:0] text;
        clk_i            = 1'b0;
        rstn_i           = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_addr_i  = '0;
        invalidate_i     = 1'b0;
        fetch_ready_i    = 1'b0;
        mem_req_ready_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_data_i  = '0;
        mem_latency      = 1;
        mem_reqs         = 0;
        cached_vld       = '0;
        limit_ns         = 0.0;
        num_tests        = 0;
        total            = 0;
        max_lat          = 0;
        fd = $fopen("verification/fetch_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            $display("SOME TESTS FAILED");
            $fatal(1, "no stimulus");
        end
        // Comment lines do not parse into five fields
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            n = $fgets(text, fd);
            if (n > 0) begin
                n = $sscanf(text, "%s %h %d %d %d", rec_name[num_tests],
                            rec_target[num_tests], rec_count[num_tests],
                            rec_lat[num_tests], rec_inval[num_tests]);
                if (n == 5) begin
                    total += rec_count[num_tests];
                    if (rec_lat[num_tests] > max_lat) begin
                        max_lat = rec_lat[num_tests];
                    end
                    num_tests++;
                end
            end
        end
        $fclose(fd);
        limit_ns = total * (max_lat + 10) * 20.0;
        repeat (15) @(posedge clk_i);
        // Outputs stay quiet while reset is held
        @(negedge clk_i);
        cur_name = "reset";
        check_value("reset_fetch_valid", 0, fetch_o.valid);
        check_value("reset_mem_req_valid", 0, mem_req_valid_o);
        check_value("reset_buffer_miss", 0, buffer_miss_o);
        @(posedge clk_i);
        #2 rstn_i = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- verification/fetch_input.txt
# name target(hex) count latency invalidate
# one test per line, count in instructions, latency in cycles
boot_seq        0080000000 24 2 0
refetch_hits    0080000000 24 1 0
far_jump        0080012344 20 4 0
inval_refetch   0080000000 24 3 1
slow_memory     00800a0008 16 8 0
back_after_inv  0080012344 12 2 1
line_crossing   008000fff8 16 1 0
short_hops      0080000404 8 5 0

//--- verilog.f
logic/fetch_pkg.sv
logic/fetch_pc_gen.sv
logic/icache_interface.sv
logic/icache_array.sv
logic/fetch_frontend.sv
verification/tb_fetch_frontend.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - logic/fetch_pkg.sv
  - logic/fetch_pc_gen.sv
  - logic/icache_interface.sv
  - logic/icache_array.sv
  - logic/fetch_frontend.sv
  - target: test
    files:
      - verification/tb_fetch_frontend.sv
